//--- dv/bpu_assert.sv
// ==============================
// BPU assertions
// Bound onto the BPU top level
// ==============================

`timescale 1ns/10ps

module bpu_assert (
  input logic                    clk_i,
  input logic                    arst_n_i,
  input logic                    flush_i,
  input bpu_cfg_pkg::addr_t      pc_i,
  input bpu_if_pkg::prediction_t pred_i,
  input logic                    btb_hit_i
);

  // Failure count, read by the testbench at the end of the run
  int fail_cnt = 0;

  // Prediction echoes the fetch address
  pc_echo_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pred_i.pc == pc_i)
    else begin
      fail_cnt++;
      $error("pred_o.pc differs from pc_i");
    end

  // Flush empties the BTB, nothing can be taken next cycle
  flush_clear_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    flush_i |=> !pred_i.taken)
    else begin
      fail_cnt++;
      $error("taken prediction one cycle after flush");
    end

  // Taken needs a target
  taken_hit_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pred_i.taken |-> btb_hit_i)
    else begin
      fail_cnt++;
      $error("taken prediction without a BTB hit");
    end

endmodule

bind bpu bpu_assert bpu_assert_inst (
  .clk_i     (clk_i),
  .arst_n_i  (arst_n_i),
  .flush_i   (flush_i),
  .pc_i      (pc_i),
  .pred_i    (pred_o),
  .btb_hit_i (btb_hit)
);

//--- dv/bpu_tb.sv
// ==============================
// BPU testbench
// Directed and random checks against a reference model
// ==============================

`timescale 1ns/10ps

module bpu_tb;

  localparam int HLEN            = 4;
  localparam int BTB_BITS        = 4;
  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int DIRECTED_CYCLES = 50;
  localparam int RAND_CYCLES     = 500;
  // Twice the expected run length
  localparam int TIMEOUT_CYCLES  = 2 * (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES);

  localparam int OFFSET    = bpu_cfg_pkg::OFFSET;
  localparam int XLEN      = bpu_cfg_pkg::XLEN;
  localparam int PHT_DEPTH = 2 ** HLEN;
  localparam int BTB_DEPTH = 2 ** BTB_BITS;
  localparam int TAG_W     = XLEN - OFFSET - BTB_BITS;

  logic                    clk;
  logic                    arst_n;
  logic                    flush;
  bpu_cfg_pkg::addr_t      pc;
  bpu_if_pkg::resolution_t res;
  bpu_if_pkg::prediction_t pred;

  // Reference model state
  logic [1:0]               m_cnt    [PHT_DEPTH];
  logic [HLEN-1:0]          m_hist;
  logic                     m_valid  [BTB_DEPTH];
  logic [TAG_W-1:0]         m_tag    [BTB_DEPTH];
  bpu_cfg_pkg::btb_target_t m_target [BTB_DEPTH];

  string              test_name;
  int                 cycle_cnt;
  bpu_cfg_pkg::addr_t branch_pc [4];

  bpu #(
    .HLEN     (HLEN),
    .BTB_BITS (BTB_BITS)
  ) bpu_inst (
    .clk_i    (clk),
    .arst_n_i (arst_n),
    .flush_i  (flush),
    .pc_i     (pc),
    .res_i    (res),
    .pred_o   (pred)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Expected prediction for a fetch address from the model state
  function automatic bpu_if_pkg::prediction_t predict(input bpu_cfg_pkg::addr_t fetch_pc);
    bpu_if_pkg::prediction_t p;
    logic [HLEN-1:0]         pidx;
    logic [BTB_BITS-1:0]     bidx;
    logic                    hit;
    pidx = fetch_pc[OFFSET +: HLEN] ^ m_hist;
    bidx = fetch_pc[OFFSET +: BTB_BITS];
    hit = m_valid[bidx] && (m_tag[bidx] == fetch_pc[XLEN-1 -: TAG_W]);
    p.pc = fetch_pc;
    p.taken = m_cnt[pidx][1] && hit;
    p.target = {m_target[bidx], {OFFSET{1'b0}}};
    return p;
  endfunction

  task automatic reset_model();
    m_hist = '0;
    for (int i = 0; i < PHT_DEPTH; i++) begin
      m_cnt[i] = 2'd1;
    end
    for (int i = 0; i < BTB_DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i] = '0;
      m_target[i] = '0;
    end
  endtask

  // One clock edge of the model
  task automatic update_model(input logic fl, input bpu_if_pkg::resolution_t r);
    logic [HLEN-1:0]     pidx;
    logic [BTB_BITS-1:0] bidx;
    pidx = r.pc[OFFSET +: HLEN] ^ m_hist;
    bidx = r.pc[OFFSET +: BTB_BITS];
    if (fl) begin
      // Counters survive a flush
      m_hist = '0;
      for (int i = 0; i < BTB_DEPTH; i++) begin
        m_valid[i] = 1'b0;
      end
    end else if (r.valid) begin
      if (r.taken && m_cnt[pidx] != 2'd3) begin
        m_cnt[pidx] = m_cnt[pidx] + 2'd1;
      end else if (!r.taken && m_cnt[pidx] != 2'd0) begin
        m_cnt[pidx] = m_cnt[pidx] - 2'd1;
      end
      m_hist = {m_hist[HLEN-2:0], r.taken};
      if (r.mispredict && r.taken) begin
        m_valid[bidx] = 1'b1;
        m_tag[bidx] = r.pc[XLEN-1 -: TAG_W];
        m_target[bidx] = r.target[XLEN-1:OFFSET];
      end else if (r.mispredict) begin
        m_valid[bidx] = 1'b0;
      end
    end
  endtask

  // Target is meaningless on a not-taken prediction
  function automatic bpu_if_pkg::prediction_t mask_target(input bpu_if_pkg::prediction_t p);
    bpu_if_pkg::prediction_t m;
    m = p;
    if (m.taken !== 1'b1) begin
      m.target = '0;
    end
    return m;
  endfunction

  task automatic check(input string name, input bpu_if_pkg::prediction_t expected,
                       input bpu_if_pkg::prediction_t actual);
    if (expected !== actual) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("tests failed");
      $fatal(1, "prediction mismatch");
    end
  endtask

  function automatic bpu_if_pkg::resolution_t make_res(input logic v, input logic mp,
                                                       input logic tk,
                                                       input bpu_cfg_pkg::addr_t bpc,
                                                       input bpu_cfg_pkg::addr_t tgt);
    bpu_if_pkg::resolution_t r;
    r.valid = v;
    r.mispredict = mp;
    r.taken = tk;
    r.pc = bpc;
    r.target = tgt;
    return r;
  endfunction

  task automatic drive(input bpu_cfg_pkg::addr_t fetch_pc, input bpu_if_pkg::resolution_t r,
                       input logic fl);
    @(posedge clk);
    pc <= fetch_pc;
    res <= r;
    flush <= fl;
  endtask

  // Same resolution for n cycles while fetching the branch itself
  task automatic resolve_branch(input int n, input logic mp, input logic tk,
                                input bpu_cfg_pkg::addr_t bpc, input bpu_cfg_pkg::addr_t tgt);
    repeat (n) begin
      drive(bpc, make_res(1'b1, mp, tk, bpc, tgt), 1'b0);
    end
  endtask

  // Idle cycle then a direct check against the expected answer
  task automatic expect_pred(input bpu_cfg_pkg::addr_t fetch_pc, input logic exp_taken,
                             input bpu_cfg_pkg::addr_t exp_target);
    bpu_if_pkg::prediction_t exp;
    drive(fetch_pc, '0, 1'b0);
    @(negedge clk);
    exp.pc = fetch_pc;
    exp.taken = exp_taken;
    exp.target = {exp_target[XLEN-1:OFFSET], {OFFSET{1'b0}}};
    check({test_name, " directed"}, mask_target(exp), mask_target(pred));
  endtask

  // Model steps on the same edges as the DUT
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reset_model();
    end else begin
      update_model(flush, res);
    end
  end

  // Every-cycle comparison against the model
  always @(negedge clk) begin
    if (bpu_inst.bpu_assert_inst.fail_cnt != 0) begin
      $display("An assertion on the BPU failed in test %s", test_name);
      $display("tests failed");
      $fatal(1, "assertion failure");
    end else if (arst_n === 1'b1) begin
      check(test_name, mask_target(predict(pc)), mask_target(pred));
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("tests failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    bpu_if_pkg::resolution_t r;
    bpu_cfg_pkg::addr_t      fpc;
    logic                    fl;
    void'($urandom(87));
    cycle_cnt = 0;
    test_name = "reset";
    arst_n = 1'b0;
    flush = 1'b0;
    pc = '0;
    res = '0;
    reset_model();
    // A and B share a BTB index with different tags
    branch_pc[0] = 32'h0000_1040;
    branch_pc[1] = 32'h0000_1080;
    // C lands on a counter that is already trained at zero history
    branch_pc[2] = 32'h0000_2004;
    branch_pc[3] = 32'h0000_300c;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    test_name = "after_reset";
    for (int i = 0; i < 16; i++) begin
      expect_pred(32'h0000_1000 + 32'(i * 4), 1'b0, '0);
    end

    // Eight taken resolutions saturate the counter at history all ones
    test_name = "install";
    resolve_branch(8, 1'b1, 1'b1, branch_pc[0], 32'h0000_4abc);
    expect_pred(branch_pc[0], 1'b1, 32'h0000_4abc);

    test_name = "delete";
    resolve_branch(1, 1'b1, 1'b0, branch_pc[0], 32'h0000_4abc);
    expect_pred(branch_pc[0], 1'b0, '0);

    test_name = "tag_miss";
    resolve_branch(4, 1'b1, 1'b1, branch_pc[0], 32'h0000_5550);
    expect_pred(branch_pc[0], 1'b1, 32'h0000_5550);
    expect_pred(branch_pc[1], 1'b0, '0);

    // Resolution at C in the flush cycle must not install
    test_name = "flush";
    drive(branch_pc[0], make_res(1'b1, 1'b1, 1'b1, branch_pc[2], 32'h0000_6660), 1'b1);
    expect_pred(branch_pc[0], 1'b0, '0);
    expect_pred(branch_pc[2], 1'b0, '0);
    // Reinstall and rebuild history while the trained counter stays set
    resolve_branch(4, 1'b1, 1'b1, branch_pc[0], 32'h0000_7770);
    expect_pred(branch_pc[0], 1'b1, 32'h0000_7770);

    test_name = "random";
    for (int i = 0; i < RAND_CYCLES; i++) begin
      if ($urandom_range(3) != 0) begin
        fpc = branch_pc[$urandom_range(3)];
      end else begin
        fpc = $urandom & ~32'h3;
      end
      r = make_res($urandom_range(1), $urandom_range(1), $urandom_range(1),
                   branch_pc[$urandom_range(3)], $urandom);
      fl = ($urandom_range(31) == 0);
      drive(fpc, r, fl);
    end
    drive('0, '0, 1'b0);
    @(negedge clk);
    #1;

    if (bpu_inst.bpu_assert_inst.fail_cnt != 0) begin
      $display("Assertion failures seen: %0d", bpu_inst.bpu_assert_inst.fail_cnt);
      $display("tests failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

//--- list.f
rtl/bpu_cfg_pkg.sv
rtl/bpu_if_pkg.sv
rtl/pht_counters.sv
rtl/gshare.sv
rtl/btb.sv
rtl/bpu.sv
dv/bpu_assert.sv
dv/bpu_tb.sv

//--- rtl/bpu.sv
// ==============================
// Branch prediction unit
// Gshare direction plus BTB target
// ==============================

`timescale 1ns/10ps

module bpu #(
  parameter int HLEN     = 4,
  parameter int BTB_BITS = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  bpu_cfg_pkg::addr_t       pc_i,
  input  bpu_if_pkg::resolution_t  res_i,
  output bpu_if_pkg::prediction_t  pred_o
);

  logic                     gshare_taken;
  logic                     btb_hit;
  logic                     btb_install;
  logic                     btb_delete;
  bpu_cfg_pkg::btb_target_t btb_target;

  // Missed taken branch, learn its target
  assign btb_install = res_i.valid & res_i.mispredict & res_i.taken;

  // Wrongly predicted taken, drop the entry
  assign btb_delete = res_i.valid & res_i.mispredict & ~res_i.taken;

  gshare #(
    .HLEN (HLEN)
  ) gshare_inst (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .pc_i     (pc_i),
    .res_i    (res_i),
    .taken_o  (gshare_taken)
  );

  btb #(
    .BTB_BITS (BTB_BITS)
  ) btb_inst (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .flush_i   (flush_i),
    .pc_i      (pc_i),
    .install_i (btb_install),
    .delete_i  (btb_delete),
    .res_i     (res_i),
    .hit_o     (btb_hit),
    .target_o  (btb_target)
  );

  // Taken only with a known target
  assign pred_o.pc     = pc_i;
  assign pred_o.taken  = gshare_taken & btb_hit;
  assign pred_o.target = {btb_target, {bpu_cfg_pkg::OFFSET{1'b0}}};

endmodule

//--- rtl/bpu_cfg_pkg.sv
// ==============================
// BPU configuration package
// Address widths and address-derived vector types
// ==============================

package bpu_cfg_pkg;

  // Instruction address width
  localparam int XLEN = 32;

  // Low PC bits that are always zero for aligned instructions
  localparam int OFFSET = 2;

  // Full instruction address
  typedef logic [XLEN-1:0] addr_t;

  // Target as kept in the BTB, low OFFSET bits dropped
  typedef logic [XLEN-OFFSET-1:0] btb_target_t;

  // Two-bit saturating counter value
  typedef logic [1:0] sat_cnt_t;

  // Counter encodings at both ends and at reset
  localparam sat_cnt_t CNT_MIN = 2'b00;
  localparam sat_cnt_t CNT_WNT = 2'b01;
  localparam sat_cnt_t CNT_MAX = 2'b11;

endpackage

//--- rtl/bpu_if_pkg.sv
// ==============================
// BPU interface package
// Resolution and prediction bundles
// ==============================

package bpu_if_pkg;

  // Branch outcome reported back from execute
  typedef struct packed {
    logic                valid;
    logic                mispredict;
    logic                taken;
    bpu_cfg_pkg::addr_t  pc;
    bpu_cfg_pkg::addr_t  target;
  } resolution_t;

  // Answer for one fetch address
  typedef struct packed {
    bpu_cfg_pkg::addr_t  pc;
    logic                taken;
    bpu_cfg_pkg::addr_t  target;
  } prediction_t;

endpackage

//--- rtl/btb.sv
// ==============================
// Branch target buffer
// Direct-mapped valid/tag/target store
// ==============================

`timescale 1ns/10ps

module btb #(
  parameter int BTB_BITS = 4
) (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      flush_i,
  input  bpu_cfg_pkg::addr_t        pc_i,
  input  logic                      install_i,
  input  logic                      delete_i,
  input  bpu_if_pkg::resolution_t   res_i,
  output logic                      hit_o,
  output bpu_cfg_pkg::btb_target_t  target_o
);

  localparam int DEPTH = 2 ** BTB_BITS;

  // Tag covers every address bit above the index
  localparam int TAG_W = bpu_cfg_pkg::XLEN - bpu_cfg_pkg::OFFSET - BTB_BITS;

  typedef logic [BTB_BITS-1:0] btb_idx_t;
  typedef logic [TAG_W-1:0]    btb_tag_t;

  logic                     valid_q  [DEPTH];
  btb_tag_t                 tag_q    [DEPTH];
  bpu_cfg_pkg::btb_target_t target_q [DEPTH];

  btb_idx_t rd_idx;
  btb_tag_t rd_tag;
  btb_idx_t wr_idx;
  btb_tag_t wr_tag;

  // Lookup fields from the fetch address
  assign rd_idx = pc_i[bpu_cfg_pkg::OFFSET +: BTB_BITS];
  assign rd_tag = pc_i[bpu_cfg_pkg::XLEN-1 -: TAG_W];

  // Update fields from the resolved branch
  assign wr_idx = res_i.pc[bpu_cfg_pkg::OFFSET +: BTB_BITS];
  assign wr_tag = res_i.pc[bpu_cfg_pkg::XLEN-1 -: TAG_W];

  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target_o = target_q[rd_idx];

  // Valid bits, cleared by reset and flush
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (flush_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (install_i) begin
      valid_q[wr_idx] <= 1'b1;
    end else if (delete_i) begin
      valid_q[wr_idx] <= 1'b0;
    end
  end

  // Tag and target payload, written only on install
  always_ff @(posedge clk_i) begin
    if (install_i && !flush_i) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= res_i.target[bpu_cfg_pkg::XLEN-1:bpu_cfg_pkg::OFFSET];
    end
  end

endmodule

//--- rtl/gshare.sv
// ==============================
// Gshare direction predictor
// Global history XOR PC indexes the counter table
// ==============================

`timescale 1ns/10ps

module gshare #(
  parameter int HLEN = 4
) (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  logic                     flush_i,
  input  bpu_cfg_pkg::addr_t       pc_i,
  input  bpu_if_pkg::resolution_t  res_i,
  output logic                     taken_o
);

  // History vector, also the counter table index width
  typedef logic [HLEN-1:0] hist_t;

  hist_t hist_q;
  hist_t rd_idx;
  hist_t wr_idx;
  logic  train;

  // Fetch side hash
  assign rd_idx = pc_i[bpu_cfg_pkg::OFFSET +: HLEN] ^ hist_q;

  // Resolve side hash, history as it stands at this edge
  assign wr_idx = res_i.pc[bpu_cfg_pkg::OFFSET +: HLEN] ^ hist_q;

  // Flush drops any resolution arriving in the same cycle
  assign train = res_i.valid & ~flush_i;

  pht_counters #(
    .HLEN (HLEN)
  ) pht_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rd_idx_i   (rd_idx),
    .rd_taken_o (taken_o),
    .wr_en_i    (train),
    .wr_idx_i   (wr_idx),
    .wr_taken_i (res_i.taken)
  );

  // Newest outcome enters at the low end
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hist_q <= '0;
    end else if (flush_i) begin
      hist_q <= '0;
    end else if (res_i.valid) begin
      hist_q <= {hist_q[HLEN-2:0], res_i.taken};
    end
  end

endmodule

//--- rtl/pht_counters.sv
// ==============================
// Pattern history table
// 2-bit saturating counters, async read, trained on edge
// ==============================

`timescale 1ns/10ps

module pht_counters #(
  parameter int HLEN = 4
) (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic [HLEN-1:0] rd_idx_i,
  output logic            rd_taken_o,
  input  logic            wr_en_i,
  input  logic [HLEN-1:0] wr_idx_i,
  input  logic            wr_taken_i
);

  localparam int DEPTH = 2 ** HLEN;

  // Counter array, one entry per history/PC hash
  bpu_cfg_pkg::sat_cnt_t cnt_q [DEPTH];

  // Current and next value of the trained entry
  bpu_cfg_pkg::sat_cnt_t wr_cnt;
  bpu_cfg_pkg::sat_cnt_t wr_cnt_nxt;

  // Upper bit set means taken
  assign rd_taken_o = cnt_q[rd_idx_i][1];

  assign wr_cnt = cnt_q[wr_idx_i];

  // One step toward the outcome, held at both ends
  always_comb begin
    wr_cnt_nxt = wr_cnt;
    if (wr_taken_i) begin
      if (wr_cnt != bpu_cfg_pkg::CNT_MAX) begin
        wr_cnt_nxt = wr_cnt + 2'd1;
      end
    end else begin
      if (wr_cnt != bpu_cfg_pkg::CNT_MIN) begin
        wr_cnt_nxt = wr_cnt - 2'd1;
      end
    end
  end

  // All counters start weakly not taken
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        cnt_q[i] <= bpu_cfg_pkg::CNT_WNT;
      end
    end else if (wr_en_i) begin
      cnt_q[wr_idx_i] <= wr_cnt_nxt;
    end
  end

endmodule
